/* rtl/bp_pkg.sv */
// shared counter type, counter update rule and default sizes, imported by the predictor blocks
`default_nettype none

package bp_pkg;

  // 2-bit saturating counter, upper bit is the predicted direction
  typedef logic [1:0] ctr_t;

  // default history and table index width
  localparam int DEF_HIST_W = 14;

  // default number of pending predictions
  localparam int DEF_QUEUE_DEPTH = 8;

  // counter field width inside a prediction tag
  localparam int TAG_CTR_W = 2;

  // one step toward 3 on taken, toward 0 on not taken
  function automatic ctr_t ctr_next(input ctr_t ctr, input logic taken);
    ctr_t nxt;
    if (taken) begin
      if (ctr == 2'b11) begin
        nxt = ctr;
      end else begin
        nxt = ctr + 2'b01;
      end
    end else begin
      if (ctr == 2'b00) begin
        nxt = ctr;
      end else begin
        nxt = ctr - 2'b01;
      end
    end
    return nxt;
  endfunction

endpackage

`default_nettype wire

/* rtl/pht_ram.sv */
// pattern history table of 2-bit counters, one registered read port and one write port
`timescale 1ns/100ps
`default_nettype none

module pht_ram #(
  parameter int hist_w = bp_pkg::DEF_HIST_W
) (
  input  wire                clk,
  input  wire                rd_en,
  input  wire [hist_w-1:0]   rd_addr,
  output bp_pkg::ctr_t       rd_data,
  input  wire                wr_en,
  input  wire [hist_w-1:0]   wr_addr,
  input  wire bp_pkg::ctr_t  wr_data
);
  import bp_pkg::*;

  localparam int depth = 1 << hist_w;

  ctr_t mem [depth];

  // simulation only, the table has no reset
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // read returns the old entry when the same slot is written in this cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/bhr_track.sv */
// architectural and speculative global history, with restore on flush and forwarding of the issuing guess
`timescale 1ns/100ps
`default_nettype none

module bhr_track #(
  parameter int hist_w = bp_pkg::DEF_HIST_W
) (
  input  wire               clk,
  input  wire               rst,
  input  wire               pred_fire,
  input  wire               pred_taken,
  input  wire               ret_en,
  input  wire               ret_taken,
  input  wire               flush,
  output logic [hist_w-1:0] spec_hist
);

  logic [hist_w-1:0] arch_bhr;
  logic [hist_w-1:0] spec_bhr;
  logic [hist_w-1:0] arch_next;
  logic [hist_w-1:0] spec_next;

  // newest outcome enters at bit 0
  assign arch_next = {arch_bhr[hist_w-2:0], ret_taken};
  assign spec_next = {spec_bhr[hist_w-2:0], pred_taken};

  // a guess leaving this cycle must already be seen by the next index
  assign spec_hist = pred_fire ? spec_next : spec_bhr;

  always_ff @(posedge clk) begin
    if (rst) begin
      arch_bhr <= '0;
    end else if (ret_en) begin
      arch_bhr <= arch_next;
    end
  end

  // restore from the committed path, including the branch retiring now
  always_ff @(posedge clk) begin
    if (rst) begin
      spec_bhr <= '0;
    end else if (flush) begin
      if (ret_en) begin
        spec_bhr <= arch_next;
      end else begin
        spec_bhr <= arch_bhr;
      end
    end else if (pred_fire) begin
      spec_bhr <= spec_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/gshare_pred.sv */
// gshare direction predictor: hashes history with the fetch address, reads a counter, trains on retirement
`timescale 1ns/100ps
`default_nettype none

module gshare_pred #(
  parameter int hist_w = bp_pkg::DEF_HIST_W
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  fetch_req,
  input  wire [31:2]                           fetch_addr,
  input  wire                                  flush,
  output logic                                 pred_valid,
  output logic                                 pred_taken,
  output logic [bp_pkg::TAG_CTR_W+hist_w-1:0]  pred_tag,
  input  wire                                  ret_en,
  input  wire                                  ret_taken,
  input  wire [bp_pkg::TAG_CTR_W+hist_w-1:0]   ret_tag
);
  import bp_pkg::*;

  localparam int tag_w = TAG_CTR_W + hist_w;

  logic              req_r;
  logic [hist_w-1:0] spec_hist;
  logic [hist_w-1:0] rd_idx;
  logic [hist_w-1:0] idx_r;
  logic [hist_w-1:0] wr_idx;
  ctr_t              rd_ctr;
  ctr_t              ret_ctr;
  ctr_t              wr_ctr;

  // skip bit 2, word pairs share an entry
  assign rd_idx = spec_hist ^ fetch_addr[hist_w+2:3];

  // request in the flush cycle is dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      req_r <= 1'b0;
    end else begin
      req_r <= fetch_req & ~flush;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req) begin
      idx_r <= rd_idx;
    end
  end

  assign pred_valid = req_r;
  assign pred_taken = rd_ctr[TAG_CTR_W-1];
  assign pred_tag   = {rd_ctr, idx_r};

  // tag layout: counter read at predict time above the table index
  assign ret_ctr = ret_tag[tag_w-1 -: TAG_CTR_W];
  assign wr_idx  = ret_tag[hist_w-1:0];
  assign wr_ctr  = ctr_next(ret_ctr, ret_taken);

  pht_ram #(
    .hist_w (hist_w)
  ) u_pht (
    .clk     (clk),
    .rd_en   (fetch_req),
    .rd_addr (rd_idx),
    .rd_data (rd_ctr),
    .wr_en   (ret_en),
    .wr_addr (wr_idx),
    .wr_data (wr_ctr)
  );

  bhr_track #(
    .hist_w (hist_w)
  ) u_bhr (
    .clk        (clk),
    .rst        (rst),
    .pred_fire  (req_r),
    .pred_taken (pred_taken),
    .ret_en     (ret_en),
    .ret_taken  (ret_taken),
    .flush      (flush),
    .spec_hist  (spec_hist)
  );

endmodule

`default_nettype wire

/* rtl/pred_queue.sv */
// in-order queue of pending prediction tags, head is the oldest unretired branch, emptied on flush
`timescale 1ns/100ps
`default_nettype none

module pred_queue #(
  parameter int queue_depth = bp_pkg::DEF_QUEUE_DEPTH,
  parameter int hist_w      = bp_pkg::DEF_HIST_W
) (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire                                  push,
  input  wire [bp_pkg::TAG_CTR_W+hist_w-1:0]   push_tag,
  input  wire                                  pop,
  input  wire                                  flush,
  output logic [bp_pkg::TAG_CTR_W+hist_w-1:0]  head_tag,
  output logic                                 empty,
  output logic                                 full
);
  import bp_pkg::*;

  localparam int tag_w = TAG_CTR_W + hist_w;
  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int cnt_w = $clog2(queue_depth + 1);

  logic [tag_w-1:0] slots [queue_depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;
  logic             at_cap;
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(queue_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign at_cap  = (count == cnt_w'(queue_depth));
  assign empty   = (count == '0);
  assign do_pop  = pop & ~empty;
  assign do_push = push & ~flush & (~at_cap | do_pop);

  // also high while the last free slot is being filled, since a request is
  // already in flight one cycle ahead of its push
  assign full = at_cap | ((count == cnt_w'(queue_depth - 1)) & push);

  assign head_tag = slots[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      slots[wr_ptr] <= push_tag;
    end
  end

endmodule

`default_nettype wire

/* rtl/bp_top.sv */
// branch predictor top: predictor plus pending queue, checks each retiring outcome and flushes on a miss
`timescale 1ns/100ps
`default_nettype none

module bp_top #(
  parameter int hist_w      = bp_pkg::DEF_HIST_W,
  parameter int queue_depth = bp_pkg::DEF_QUEUE_DEPTH
) (
  input  wire        clk,
  input  wire        rst,
  input  wire        fetch_req,
  input  wire [31:2] fetch_addr,
  output logic       pred_valid,
  output logic       pred_taken,
  output logic       queue_full,
  input  wire        ret_valid,
  input  wire        ret_taken,
  output logic       mispredict
);
  import bp_pkg::*;

  localparam int tag_w = TAG_CTR_W + hist_w;

  logic [tag_w-1:0] pred_tag;
  logic [tag_w-1:0] head_tag;
  logic             queue_empty;
  logic             ret_en;
  logic             head_taken;
  logic             flush;

  // retire only against a real entry
  assign ret_en = ret_valid & ~queue_empty;

  // guess stored with the head entry
  assign head_taken = head_tag[tag_w-1];

  assign flush = ret_en & (head_taken != ret_taken);

  always_ff @(posedge clk) begin
    if (rst) begin
      mispredict <= 1'b0;
    end else begin
      mispredict <= flush;
    end
  end

  gshare_pred #(
    .hist_w (hist_w)
  ) u_pred (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .flush      (flush),
    .pred_valid (pred_valid),
    .pred_taken (pred_taken),
    .pred_tag   (pred_tag),
    .ret_en     (ret_en),
    .ret_taken  (ret_taken),
    .ret_tag    (head_tag)
  );

  // flush drops every entry, the retiring head among them
  pred_queue #(
    .queue_depth (queue_depth),
    .hist_w      (hist_w)
  ) u_queue (
    .clk      (clk),
    .rst      (rst),
    .push     (pred_valid),
    .push_tag (pred_tag),
    .pop      (ret_en),
    .flush    (flush),
    .head_tag (head_tag),
    .empty    (queue_empty),
    .full     (queue_full)
  );

endmodule

`default_nettype wire

/* sim/bp_props.sv */
// protocol assertions on the predictor top, attached to every bp_top instance by bind
`timescale 1ns/100ps
`default_nettype none

module bp_props (
  input wire clk,
  input wire rst,
  input wire fetch_req,
  input wire queue_full,
  input wire ret_valid,
  input wire queue_empty,
  input wire flush,
  input wire pred_valid,
  input wire mispredict
);

  // fetch must wait while the queue is full
  no_fetch_when_full: assert property (
    @(posedge clk) disable iff (rst) queue_full |-> !fetch_req
  ) else $error("fetch_req raised while queue_full is high");

  // a retirement needs a pending prediction
  no_retire_when_empty: assert property (
    @(posedge clk) disable iff (rst) queue_empty |-> !ret_valid
  ) else $error("ret_valid raised with no pending prediction");

  valid_after_fetch: assert property (
    @(posedge clk) disable iff (rst) (fetch_req && !flush) |=> pred_valid
  ) else $error("pred_valid missing one cycle after fetch_req");

  valid_only_after_fetch: assert property (
    @(posedge clk) disable iff (rst) pred_valid |-> $past(fetch_req && !flush)
  ) else $error("pred_valid without a fetch_req one cycle earlier");

  single_mispredict: assert property (
    @(posedge clk) disable iff (rst) mispredict |=> !mispredict
  ) else $error("mispredict high on two consecutive cycles");

endmodule

bind bp_top bp_props u_props (
  .clk         (clk),
  .rst         (rst),
  .fetch_req   (fetch_req),
  .queue_full  (queue_full),
  .ret_valid   (ret_valid),
  .queue_empty (queue_empty),
  .flush       (flush),
  .pred_valid  (pred_valid),
  .mispredict  (mispredict)
);

`default_nettype wire

/* sim/bp_tb.sv */
// top-level testbench that drives bp_top with directed and random tests checked against a model
`timescale 1ns/100ps
`default_nettype none

module bp_tb;
  import bp_pkg::*;

  localparam int hw     = DEF_HIST_W;
  localparam int qd     = DEF_QUEUE_DEPTH;
  localparam int tag_w  = TAG_CTR_W + hw;
  localparam int n_rand = 200;
  // directed tests take about 270 cycles and the random mix one per operation
  localparam int n_ops       = 280 + n_rand;
  localparam int cycle_limit = 40 * n_ops + 200;
  localparam logic [31:2] train_addr = 30'h0012_3456;

  logic        clk;
  logic        rst;
  logic        fetch_req;
  logic [31:2] fetch_addr;
  logic        ret_valid;
  logic        ret_taken;
  logic        pred_valid;
  logic        pred_taken;
  logic        queue_full;
  logic        mispredict;

  // model of counters, both histories, the registered read and the pending queue
  ctr_t             ref_pht [1 << hw];
  logic [hw-1:0]    ref_arch;
  logic [hw-1:0]    ref_spec;
  logic             ref_req;
  logic [hw-1:0]    ref_idx;
  ctr_t             ref_ctr;
  logic             ref_misp;
  logic [tag_w-1:0] ref_q [$];

  integer seed;
  int     cycles;
  string  test_name;
  int     err_valid;
  int     err_taken;
  int     err_misp;
  int     err_full;
  int     err_empty;

  bp_top #(
    .hist_w      (hw),
    .queue_depth (qd)
  ) uut (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .pred_valid (pred_valid),
    .pred_taken (pred_taken),
    .queue_full (queue_full),
    .ret_valid  (ret_valid),
    .ret_taken  (ret_taken),
    .mispredict (mispredict)
  );

  always #2 clk = ~clk;

  // saturating step clamped at 0 and 3
  function automatic ctr_t train_ctr(input ctr_t c, input logic taken);
    int v;
    v = int'(c) + (taken ? 1 : -1);
    if (v < 0) begin
      v = 0;
    end
    if (v > 3) begin
      v = 3;
    end
    return v[1:0];
  endfunction

  // full when queued plus issuing predictions fill every slot
  function automatic logic expect_full();
    return (ref_q.size() + int'(ref_req)) >= qd;
  endfunction

  function automatic logic head_guess();
    if (ref_q.size() == 0) begin
      return 1'b0;
    end
    return ref_q[0][tag_w-1];
  endfunction

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      err_valid++;
      $display("[FAIL] %0t %s: pred_valid %b, expected %b", $time, test_name, got, exp);
    end
  endtask

  task automatic check_taken(input logic got, input logic exp);
    if (got !== exp) begin
      err_taken++;
      $display("[FAIL] %0t %s: pred_taken %b, expected %b", $time, test_name, got, exp);
    end
  endtask

  task automatic check_mispredict(input logic got, input logic exp);
    if (got !== exp) begin
      err_misp++;
      $display("[FAIL] %0t %s: mispredict %b, expected %b", $time, test_name, got, exp);
    end
  endtask

  task automatic check_full(input logic got, input logic exp);
    if (got !== exp) begin
      err_full++;
      $display("[FAIL] %0t %s: queue_full %b, expected %b", $time, test_name, got, exp);
    end
  endtask

  task automatic check_empty(input logic got, input logic exp);
    if (got !== exp) begin
      err_empty++;
      $display("[FAIL] %0t %s: queue empty %b, expected %b", $time, test_name, got, exp);
    end
  endtask

  // one clock that checks the last edge's outputs, drives inputs and steps the model
  task automatic run_cycle(input logic f, input logic [31:2] a, input logic r, input logic t);
    logic             pv;
    logic             pt;
    logic             ret_en;
    logic             flush;
    logic [hw-1:0]    sh;
    logic [hw-1:0]    idx;
    logic [hw-1:0]    arch_new;
    logic [tag_w-1:0] head;
    logic [tag_w-1:0] pushed;
    pv = ref_req;
    pt = ref_ctr[TAG_CTR_W-1];
    check_valid(pred_valid, pv);
    if (pv) begin
      check_taken(pred_taken, pt);
    end
    check_mispredict(mispredict, ref_misp);
    check_full(queue_full, expect_full());
    check_empty(uut.queue_empty, ref_q.size() == 0);

    fetch_req  = f;
    fetch_addr = a;
    ret_valid  = r;
    ret_taken  = t;

    // the guess leaving now already counts for this index
    sh       = pv ? {ref_spec[hw-2:0], pt} : ref_spec;
    idx      = sh ^ a[hw+2:3];
    ret_en   = r && (ref_q.size() > 0);
    head     = '0;
    if (ret_en) begin
      head = ref_q[0];
    end
    flush    = ret_en && (head[tag_w-1] != t);
    arch_new = {ref_arch[hw-2:0], t};
    pushed   = {ref_ctr, ref_idx};

    @(posedge clk);
    // read sees the entry as it was before this edge's write
    if (f) begin
      ref_ctr = ref_pht[idx];
      ref_idx = idx;
    end
    if (ret_en) begin
      ref_pht[head[hw-1:0]] = train_ctr(head[tag_w-1 -: TAG_CTR_W], t);
      ref_arch = arch_new;
    end
    if (flush) begin
      ref_spec = arch_new;
      ref_q.delete();
    end else begin
      if (pv) begin
        ref_spec = {ref_spec[hw-2:0], pt};
      end
      if (ret_en) begin
        head = ref_q.pop_front();
      end
      if (pv) begin
        ref_q.push_back(pushed);
      end
    end
    ref_req  = f && !flush;
    ref_misp = flush;
    @(negedge clk);
  endtask

  task automatic retire_all();
    while (ref_q.size() > 0 || ref_req) begin
      run_cycle(1'b0, '0, ref_q.size() > 0, head_guess());
    end
    run_cycle(1'b0, '0, 1'b0, 1'b0);
  endtask

  // fetch once and retire the guess with outcome t after it appears
  task automatic train(input logic t, input int n);
    for (int i = 0; i < n; i++) begin
      run_cycle(1'b1, train_addr, 1'b0, 1'b0);
      run_cycle(1'b0, '0, 1'b0, 1'b0);
      run_cycle(1'b0, '0, 1'b1, t);
    end
  endtask

  task automatic reset_guesses();
    logic [31:2] a;
    test_name = "reset";
    for (int i = 0; i < 4; i++) begin
      a = 30'(32'h0004_0000 + i * 32'h0000_0a28);
      run_cycle(1'b1, a, 1'b0, 1'b0);
      run_cycle(1'b0, '0, 1'b0, 1'b0);
    end
    retire_all();
  endtask

  // long enough for the history to fill and the index to settle
  task automatic train_counter();
    test_name = "training";
    train(1'b1, 18);
    train(1'b0, 18);
    retire_all();
  endtask

  task automatic back_to_back();
    logic [31:0] adr;
    test_name = "back to back";
    train(1'b1, 18);
    for (int i = 0; i < 6; i++) begin
      adr = $random(seed);
      run_cycle(1'b1, i[0] ? adr[31:2] : train_addr, 1'b0, 1'b0);
    end
    retire_all();
  endtask

  task automatic flush_on_miss();
    logic [31:0] adr;
    test_name = "mispredict";
    // all-taken history so the restored path reaches a trained counter
    train(1'b1, 18);
    adr = $random(seed);
    run_cycle(1'b1, adr[31:2], 1'b0, 1'b0);
    run_cycle(1'b1, train_addr, 1'b0, 1'b0);
    run_cycle(1'b0, '0, 1'b0, 1'b0);
    // wrong outcome for the head drops the fetch in the same cycle
    run_cycle(1'b1, adr[31:2], 1'b1, !head_guess());
    run_cycle(1'b1, train_addr, 1'b0, 1'b0);
    retire_all();
  endtask

  task automatic fill_queue();
    logic [31:0] adr;
    test_name = "queue full";
    while (ref_q.size() < qd) begin
      adr = $random(seed);
      run_cycle(!expect_full(), adr[31:2], 1'b0, 1'b0);
    end
    run_cycle(1'b0, '0, 1'b0, 1'b0);
    run_cycle(1'b0, '0, 1'b1, head_guess());
    retire_all();
  endtask

  task automatic random_mix();
    logic [31:0] ctl;
    logic [31:0] adr;
    logic        t;
    test_name = "random";
    for (int i = 0; i < n_rand; i++) begin
      ctl = $random(seed);
      adr = $random(seed);
      // about one retirement in four goes against the guess
      t = (ctl[3:2] == 2'b00) ? !head_guess() : head_guess();
      run_cycle(ctl[0] && !expect_full(), adr[31:2], ctl[1] && (ref_q.size() > 0), t);
    end
    retire_all();
  endtask

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    $timeformat(-9, 1, " ns", 0);
    seed       = 32'h4df7_4af4;
    clk        = 1'b0;
    rst        = 1'b1;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    ret_valid  = 1'b0;
    ret_taken  = 1'b0;
    err_valid  = 0;
    err_taken  = 0;
    err_misp   = 0;
    err_full   = 0;
    err_empty  = 0;
    test_name  = "init";
    for (int i = 0; i < (1 << hw); i++) begin
      ref_pht[i] = '0;
    end
    ref_arch = '0;
    ref_spec = '0;
    ref_req  = 1'b0;
    ref_idx  = '0;
    ref_ctr  = '0;
    ref_misp = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    reset_guesses();
    train_counter();
    back_to_back();
    flush_on_miss();
    fill_queue();
    random_mix();

    $display("errors: valid=%0d taken=%0d mispredict=%0d full=%0d empty=%0d",
             err_valid, err_taken, err_misp, err_full, err_empty);
    if (err_valid + err_taken + err_misp + err_full + err_empty == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
rtl/bp_pkg.sv
rtl/pht_ram.sv
rtl/bhr_track.sv
rtl/gshare_pred.sv
rtl/pred_queue.sv
rtl/bp_top.sv
sim/bp_props.sv
sim/bp_tb.sv

/* Makefile */
# Verilator build and run of the branch predictor testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module bp_tb -f all.f -o bp_sim

run: compile
	./obj_dir/bp_sim | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
